/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen            = 32;
    localparam int dmem_words_dflt = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r;
        s_view_t s;
        u_view_t u;
    } inst_u;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;
    typedef enum logic [1:0] {op2_rs2, op2_imi, op2_ims, op2_imu} op2_sel_e;
    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_xor} alu_op_e;

    typedef struct packed {
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        alu_op_e   alu_op;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
    } ctrl_t;

    typedef enum logic [1:0] {fw_sel_exe, fw_sel_mem, fw_sel_wbk} fw_sel_e;

endpackage

/* source/fw_bus_if.sv */
`timescale 1ns/10ps

interface fw_bus_if import rv_pkg::*; ();

    logic      valid;
    reg_addr_t addr;
    word_t     wdata;
    logic      fwdable;   // Low while a load result is still in flight.

    modport producer (
        output valid, addr, wdata, fwdable
    );

    modport consumer (
        input valid, addr, wdata, fwdable
    );

endinterface

/* source/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_req,
    output logic      inst_ack,
    input  inst_u     inst,
    input  word_t     pc,
    input  logic      stall,
    output logic      valid,
    output word_t     pc_q,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output ctrl_t     ctrl,
    output word_t     imm_i,
    output word_t     imm_s,
    output word_t     imm_u
);

    inst_u inst_q;
    logic  take;

    assign take = inst_req && !inst_ack && (!valid || !stall);   // Slot empty or leaving now.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= 1'b0;
            inst_ack <= 1'b0;
            inst_q   <= '0;
        end else if (take) begin
            valid    <= 1'b1;
            inst_ack <= 1'b1;
            inst_q   <= inst;
        end else begin
            if (valid && !stall) begin
                valid <= 1'b0;
            end
            if (inst_ack && !inst_req) begin
                inst_ack <= 1'b0;   // Return to zero after the source drops req.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q <= pc;
        end
    end

    assign rs1_addr = inst_q.r.rs1;
    assign rs2_addr = inst_q.r.rs2;
    assign imm_i    = {{20{inst_q.r.funct7[6]}}, inst_q.r.funct7, inst_q.r.rs2};
    assign imm_s    = {{20{inst_q.s.imm_hi[6]}}, inst_q.s.imm_hi, inst_q.s.imm_lo};
    assign imm_u    = {inst_q.u.imm, 12'h000};

    always_comb begin
        logic    f3_ok;
        alu_op_e alu;
        f3_ok = 1'b1;
        case (inst_q.r.funct3)
            3'b000:  alu = (inst_q.r.opcode == opc_op && inst_q.r.funct7[5]) ? alu_sub : alu_add;
            3'b100:  alu = alu_xor;
            3'b110:  alu = alu_or;
            3'b111:  alu = alu_and;
            default: begin
                alu   = alu_add;
                f3_ok = 1'b0;
            end
        endcase
        ctrl         = '0;   // Anything unknown retires as a no-op.
        ctrl.op1_sel = op1_zero;
        ctrl.op2_sel = op2_imi;
        ctrl.alu_op  = alu_add;
        case (inst_q.r.opcode)
            opc_op: begin
                ctrl.op1_sel   = op1_rs1;
                ctrl.op2_sel   = op2_rs2;
                ctrl.alu_op    = alu;
                ctrl.reg_write = f3_ok;
            end
            opc_op_imm: begin
                ctrl.op1_sel   = op1_rs1;
                ctrl.alu_op    = alu;
                ctrl.reg_write = f3_ok;
            end
            opc_lui: begin
                ctrl.op2_sel   = op2_imu;
                ctrl.reg_write = 1'b1;
            end
            opc_auipc: begin
                ctrl.op1_sel   = op1_pc;
                ctrl.op2_sel   = op2_imu;
                ctrl.reg_write = 1'b1;
            end
            opc_load: begin
                ctrl.op1_sel   = op1_rs1;
                ctrl.reg_write = (inst_q.r.funct3 == 3'b010);
                ctrl.mem_read  = (inst_q.r.funct3 == 3'b010);
            end
            opc_store: begin
                ctrl.op1_sel   = op1_rs1;
                ctrl.op2_sel   = op2_ims;
                ctrl.mem_write = (inst_q.s.funct3 == 3'b010);
            end
            default: ;
        endcase
        ctrl.rd = ctrl.reg_write ? inst_q.r.rd : '0;
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd
);

    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];   // x0 is hardwired.
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* source/data_select_stage.sv */
`timescale 1ns/10ps

module data_select_stage import rv_pkg::*; (
    input  logic       valid,
    input  word_t      pc,
    input  reg_addr_t  rs1_addr,
    input  reg_addr_t  rs2_addr,
    input  ctrl_t      ctrl,
    input  word_t      imm_i,
    input  word_t      imm_s,
    input  word_t      imm_u,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    fw_bus_if.consumer fw_exe,
    fw_bus_if.consumer fw_mem,
    fw_bus_if.consumer fw_wbk,
    output word_t      next_op1_data,
    output word_t      next_op2_data,
    output word_t      next_rs2_data,
    output logic       is_datahazard
);

    function automatic fw_sel_e pick(input logic [2:0] hit);
        fw_sel_e sel;
        if (hit[fw_sel_exe]) sel = fw_sel_exe;   // Youngest result wins.
        else if (hit[fw_sel_mem]) sel = fw_sel_mem;
        else sel = fw_sel_wbk;
        return sel;
    endfunction

    logic [2:0]      fw_valid;
    logic [2:0]      fw_ok;
    reg_addr_t [2:0] fw_addr;
    word_t [2:0]     fw_wdata;
    logic [2:0]      hit1;
    logic [2:0]      hit2;
    fw_sel_e         src1;
    fw_sel_e         src2;
    word_t           rs1_val;
    word_t           rs2_val;
    logic            use1;
    logic            use2;

    assign fw_valid = {fw_wbk.valid, fw_mem.valid, fw_exe.valid};
    assign fw_ok    = {fw_wbk.fwdable, fw_mem.fwdable, fw_exe.fwdable};
    assign fw_addr  = {fw_wbk.addr, fw_mem.addr, fw_exe.addr};
    assign fw_wdata = {fw_wbk.wdata, fw_mem.wdata, fw_exe.wdata};

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            hit1[i] = fw_valid[i] && fw_addr[i] == rs1_addr && rs1_addr != '0;
            hit2[i] = fw_valid[i] && fw_addr[i] == rs2_addr && rs2_addr != '0;
        end
    end

    assign src1    = pick(hit1);
    assign src2    = pick(hit2);
    assign rs1_val = (|hit1) ? fw_wdata[src1] : rs1_data;
    assign rs2_val = (|hit2) ? fw_wdata[src2] : rs2_data;

    // Only operands the instruction really reads can stall it.
    assign use1 = ctrl.op1_sel == op1_rs1;
    assign use2 = ctrl.op2_sel == op2_rs2 || ctrl.mem_write;

    assign is_datahazard = valid && ((use1 && |hit1 && !fw_ok[src1]) ||
                                     (use2 && |hit2 && !fw_ok[src2]));

    always_comb begin
        case (ctrl.op1_sel)
            op1_rs1: next_op1_data = rs1_val;
            op1_pc:  next_op1_data = pc;
            default: next_op1_data = '0;
        endcase
        case (ctrl.op2_sel)
            op2_rs2: next_op2_data = rs2_val;
            op2_imi: next_op2_data = imm_i;
            op2_ims: next_op2_data = imm_s;
            default: next_op2_data = imm_u;
        endcase
    end

    assign next_rs2_data = rs2_val;   // Store data.

endmodule

/* source/exec_stage.sv */
`timescale 1ns/10ps

module exec_stage import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       valid,
    input  logic       stall,
    input  ctrl_t      ctrl,
    input  word_t      pc,
    input  word_t      op1,
    input  word_t      op2,
    input  word_t      rs2,
    fw_bus_if.producer fw_exe,
    output logic       exe_valid,
    output ctrl_t      exe_ctrl,
    output word_t      exe_alu_result,
    output word_t      exe_store_data,
    output word_t      exe_pc
);

    word_t op1_q;
    word_t op2_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
            exe_ctrl  <= '0;
        end else begin
            exe_valid <= valid && !stall;   // Bubble while the hazard holds.
            exe_ctrl  <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        op1_q          <= op1;
        op2_q          <= op2;
        exe_store_data <= rs2;
        exe_pc         <= pc;
    end

    always_comb begin
        case (exe_ctrl.alu_op)
            alu_sub: exe_alu_result = op1_q - op2_q;
            alu_and: exe_alu_result = op1_q & op2_q;
            alu_or:  exe_alu_result = op1_q | op2_q;
            alu_xor: exe_alu_result = op1_q ^ op2_q;
            default: exe_alu_result = op1_q + op2_q;
        endcase
    end

    assign fw_exe.valid   = exe_valid && exe_ctrl.reg_write && exe_ctrl.rd != '0;
    assign fw_exe.addr    = exe_ctrl.rd;
    assign fw_exe.wdata   = exe_alu_result;
    assign fw_exe.fwdable = !exe_ctrl.mem_read;   // Load address, not data.

endmodule

/* source/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage import rv_pkg::*; #(
    parameter int dmem_words = dmem_words_dflt
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       exe_valid,
    input  ctrl_t      exe_ctrl,
    input  word_t      exe_alu_result,
    input  word_t      exe_store_data,
    input  word_t      exe_pc,
    fw_bus_if.producer fw_mem,
    fw_bus_if.producer fw_wbk,
    output logic       we,
    output reg_addr_t  wa,
    output word_t      wd,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_addr_t  retire_rd,
    output word_t      retire_data
);

    localparam int dmem_aw = $clog2(dmem_words);

    word_t              ram [dmem_words];
    logic               mem_valid;
    ctrl_t              mem_ctrl;
    word_t              mem_result;
    word_t              mem_store_data;
    word_t              mem_pc;
    logic [dmem_aw-1:0] ram_addr;
    logic               wbk_valid;
    ctrl_t              wbk_ctrl;
    word_t              wbk_data;
    word_t              wbk_pc;

    assign ram_addr = mem_result[dmem_aw+1:2];   // Word addressed.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_ctrl  <= '0;
            wbk_valid <= 1'b0;
            wbk_ctrl  <= '0;
            for (int i = 0; i < dmem_words; i++) begin
                ram[i] <= '0;
            end
        end else begin
            mem_valid <= exe_valid;
            mem_ctrl  <= exe_ctrl;
            wbk_valid <= mem_valid;
            wbk_ctrl  <= mem_ctrl;
            if (mem_valid && mem_ctrl.mem_write) begin
                ram[ram_addr] <= mem_store_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= exe_alu_result;
        mem_store_data <= exe_store_data;
        mem_pc         <= exe_pc;
        wbk_data       <= mem_ctrl.mem_read ? ram[ram_addr] : mem_result;
        wbk_pc         <= mem_pc;
    end

    assign fw_mem.valid   = mem_valid && mem_ctrl.reg_write && mem_ctrl.rd != '0;
    assign fw_mem.addr    = mem_ctrl.rd;
    assign fw_mem.wdata   = mem_result;
    assign fw_mem.fwdable = !mem_ctrl.mem_read;   // RAM data lands next edge.

    assign we = wbk_valid && wbk_ctrl.reg_write;
    assign wa = wbk_ctrl.rd;
    assign wd = wbk_data;

    assign fw_wbk.valid   = we && wbk_ctrl.rd != '0;
    assign fw_wbk.addr    = wbk_ctrl.rd;
    assign fw_wbk.wdata   = wbk_data;
    assign fw_wbk.fwdable = 1'b1;

    assign retire_valid = wbk_valid;
    assign retire_pc    = wbk_pc;
    assign retire_rd    = wbk_ctrl.rd;
    assign retire_data  = fw_wbk.valid ? wbk_data : '0;   // Stores and x0 report zero.

endmodule

/* source/operand_core.sv */
`timescale 1ns/10ps

module operand_core import rv_pkg::*; #(
    parameter int dmem_words = dmem_words_dflt
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_req,
    output logic      inst_ack,
    input  inst_u     inst,
    input  word_t     pc,
    output logic      retire_valid,
    output word_t     retire_pc,
    output reg_addr_t retire_rd,
    output word_t     retire_data
);

    logic      dec_valid;
    word_t     dec_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    ctrl_t     dec_ctrl;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_u;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     next_op1_data;
    word_t     next_op2_data;
    word_t     next_rs2_data;
    logic      is_datahazard;
    logic      exe_valid;
    ctrl_t     exe_ctrl;
    word_t     exe_alu_result;
    word_t     exe_store_data;
    word_t     exe_pc;
    logic      rf_we;
    reg_addr_t rf_wa;
    word_t     rf_wd;

    fw_bus_if fw_exe ();
    fw_bus_if fw_mem ();
    fw_bus_if fw_wbk ();

    inst_decoder u_dec (
        .clk, .rst_n, .inst_req, .inst_ack, .inst, .pc,
        .stall(is_datahazard), .valid(dec_valid), .pc_q(dec_pc),
        .rs1_addr, .rs2_addr, .ctrl(dec_ctrl), .imm_i, .imm_s, .imm_u
    );

    reg_file u_rf (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we(rf_we), .wa(rf_wa), .wd(rf_wd)
    );

    data_select_stage u_sel (
        .valid(dec_valid), .pc(dec_pc), .rs1_addr, .rs2_addr, .ctrl(dec_ctrl),
        .imm_i, .imm_s, .imm_u, .rs1_data, .rs2_data,
        .fw_exe(fw_exe.consumer), .fw_mem(fw_mem.consumer), .fw_wbk(fw_wbk.consumer),
        .next_op1_data, .next_op2_data, .next_rs2_data, .is_datahazard
    );

    exec_stage u_exe (
        .clk, .rst_n, .valid(dec_valid), .stall(is_datahazard), .ctrl(dec_ctrl),
        .pc(dec_pc), .op1(next_op1_data), .op2(next_op2_data), .rs2(next_rs2_data),
        .fw_exe(fw_exe.producer),
        .exe_valid, .exe_ctrl, .exe_alu_result, .exe_store_data, .exe_pc
    );

    mem_stage #(.dmem_words(dmem_words)) u_mem (
        .clk, .rst_n, .exe_valid, .exe_ctrl, .exe_alu_result, .exe_store_data, .exe_pc,
        .fw_mem(fw_mem.producer), .fw_wbk(fw_wbk.producer),
        .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

endmodule

/* bench/tb_tests.svh */
`ifndef tb_tests_svh
`define tb_tests_svh

task automatic reset_state_check();
    check_bit(inst_ack, 1'b0, "inst_ack after reset");
    check_bit(retire_valid, 1'b0, "retire_valid after reset");
    repeat (3) @(negedge clk);
    check_bit(retire_valid, 1'b0, "retire_valid while idle");
    op_i(3'b000, 5'd1, 5'd0, 12'd1);
    op_i(3'b000, 5'd2, 5'd0, 12'd2);
    op_i(3'b000, 5'd3, 5'd0, 12'd3);
    drain();
endtask

task automatic r_type_ops();
    for (int r = 1; r <= 8; r++) begin
        op_i(3'b000, reg_addr_t'(r), 5'd0, 12'($urandom()));
    end
    op_lui(5'd9, 20'($urandom()));
    op_i(3'b000, 5'd9, 5'd9, 12'($urandom()));   // Full 32-bit random value.
    op_r(3'b000, 1'b0, 5'd10, 5'd1, 5'd2);
    op_r(3'b000, 1'b1, 5'd11, 5'd3, 5'd4);
    op_r(3'b100, 1'b0, 5'd12, 5'd5, 5'd6);
    op_r(3'b110, 1'b0, 5'd13, 5'd7, 5'd8);
    op_r(3'b111, 1'b0, 5'd14, 5'd9, 5'd8);
    op_r(3'b000, 1'b1, 5'd18, 5'd9, 5'd1);
    op_i(3'b000, 5'd15, 5'd0, 12'd1);
    op_i(3'b000, 5'd16, 5'd0, 12'd2);
    op_r(3'b000, 1'b1, 5'd17, 5'd15, 5'd16);   // 1 - 2 wraps to all ones.
    drain();
endtask

task automatic i_type_and_upper();
    op_i(3'b000, 5'd1, 5'd0, 12'hfff);
    op_i(3'b111, 5'd2, 5'd10, 12'h800);
    op_i(3'b110, 5'd3, 5'd11, 12'h0f0);
    op_i(3'b100, 5'd4, 5'd12, 12'hfff);   // XORI with -1 inverts.
    op_i(3'b100, 5'd5, 5'd13, 12'($urandom()));
    op_i(3'b110, 5'd6, 5'd14, 12'($urandom()));
    op_lui(5'd7, 20'($urandom()));
    op_lui(5'd8, 20'h80000);
    op_auipc(5'd9, 20'h00001);
    op_auipc(5'd18, 20'($urandom()));
    op_i(3'b000, 5'd19, 5'd7, 12'h801);
    drain();
endtask

task automatic forwarding_chains();
    op_i(3'b000, 5'd1, 5'd0, 12'd5);
    op_i(3'b000, 5'd1, 5'd1, 12'd7);
    op_r(3'b000, 1'b0, 5'd2, 5'd1, 5'd1);
    op_r(3'b000, 1'b1, 5'd3, 5'd2, 5'd1);
    op_r(3'b100, 1'b0, 5'd3, 5'd3, 5'd2);
    op_i(3'b110, 5'd3, 5'd3, 12'h700);
    op_r(3'b000, 1'b0, 5'd4, 5'd3, 5'd1);   // Newest x3, older x1.
    op_lui(5'd5, 20'($urandom()));
    op_i(3'b100, 5'd5, 5'd5, 12'($urandom()));
    op_r(3'b111, 1'b0, 5'd6, 5'd5, 5'd5);
    drain();
endtask

task automatic load_store_roundtrip();
    op_i(3'b000, 5'd21, 5'd0, 12'h040);
    op_i(3'b000, 5'd20, 5'd0, 12'($urandom()));
    op_sw(5'd20, 5'd21, 12'd8);
    op_lw(5'd22, 5'd21, 12'd8);
    op_lw(5'd23, 5'd21, 12'd8);
    op_r(3'b000, 1'b0, 5'd24, 5'd23, 5'd20);   // Load then use.
    op_r(3'b100, 1'b0, 5'd24, 5'd24, 5'd23);   // Stalled result forwarded from exe.
    op_r(3'b000, 1'b1, 5'd31, 5'd24, 5'd20);   // Mem result wins over wbk for x24.
    op_sw(5'd23, 5'd21, 12'hffc);
    op_lw(5'd25, 5'd21, 12'hffc);
    op_sw(5'd25, 5'd21, 12'd12);   // Store data straight from a load.
    op_lw(5'd26, 5'd21, 12'd12);
    op_i(3'b100, 5'd26, 5'd26, 12'h555);
    for (int k = 0; k < 4; k++) begin
        op_i(3'b000, 5'd27, 5'd0, 12'($urandom()));
        op_sw(5'd27, 5'd21, 12'(16 + 4 * k));
    end
    for (int k = 0; k < 4; k++) begin
        op_lw(5'd28, 5'd21, 12'(16 + 4 * k));
        op_r(3'b000, 1'b0, 5'd29, 5'd28, 5'd29);
    end
    op_lw(5'd30, 5'd0, 12'h100);   // Aliases word 0.
    drain();
endtask

task automatic x0_writes();
    op_i(3'b000, 5'd0, 5'd0, 12'd55);
    op_r(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
    op_lui(5'd0, 20'habcde);
    op_r(3'b000, 1'b0, 5'd27, 5'd0, 5'd0);
    op_i(3'b110, 5'd28, 5'd0, 12'h123);
    op_lw(5'd0, 5'd21, 12'd8);
    issue({12'h123, 5'd1, 3'b000, 5'd3, 7'b1111111}, 5'd0, 32'h0);   // Unknown opcode.
    op_r(3'b100, 1'b0, 5'd29, 5'd0, 5'd28);
    drain();
endtask

`endif

/* bench/tb_operand_core.sv */
`timescale 1ns/10ps

module tb_operand_core import rv_pkg::*; ();

    localparam int dmem_words = 64;
    localparam int clk_period = 10;
    localparam int inst_count = 90;   // Upper bound on instructions sent by all tests.
    localparam int hs_limit   = 20;

    logic      clk;
    logic      rst_n;
    logic      inst_req;
    logic      inst_ack;
    inst_u     inst;
    word_t     pc;
    logic      retire_valid;
    word_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_data;

    word_t     model_rf [32];
    word_t     model_mem [dmem_words];
    word_t     pc_next;
    word_t     exp_pc [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    int        err_value;
    int        err_proto;
    int        n_sent;
    int        n_retired;

    operand_core #(.dmem_words(dmem_words)) dut0 (
        .clk, .rst_n, .inst_req, .inst_ack, .inst, .pc,
        .retire_valid, .retire_pc, .retire_rd, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(clk_period * (inst_count * 20 + 200));
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic int mem_index(input word_t addr);
        word_t idx;
        idx = (addr >> 2) % word_t'(dmem_words);   // Word RAM wraps at its depth.
        return int'(idx);
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic sub,
                                        input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = sub ? a - b : a + b;
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Four-phase master, starts and ends just after a falling edge.
    task automatic handshake(input word_t word, input word_t addr);
        int waited;
        inst     = word;
        pc       = addr;
        inst_req = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!inst_ack && waited < hs_limit);
        if (!inst_ack) begin
            err_proto++;
            $display("inst_ack never rose for the instruction at pc %08h", addr);
            inst_req = 1'b0;
            return;
        end
        inst_req = 1'b0;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (inst_ack && waited < hs_limit);
        if (inst_ack) begin
            err_proto++;
            $display("inst_ack stayed high after inst_req fell at pc %08h", addr);
        end
    endtask

    task automatic issue(input word_t word, input reg_addr_t rd, input word_t value);
        exp_pc.push_back(pc_next);
        exp_rd.push_back(rd);
        exp_data.push_back((rd == 5'd0) ? 32'h0 : value);
        if (rd != 5'd0) begin
            model_rf[rd] = value;
        end
        n_sent++;
        handshake(word, pc_next);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic op_r(input logic [2:0] f3, input logic sub, input reg_addr_t rd,
                        input reg_addr_t rs1, input reg_addr_t rs2);
        issue({1'b0, sub, 5'b0, rs2, rs1, f3, rd, opc_op}, rd,
              alu_model(f3, sub, model_rf[rs1], model_rf[rs2]));
    endtask

    task automatic op_i(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                        input logic [11:0] imm);
        issue({imm, rs1, f3, rd, opc_op_imm}, rd,
              alu_model(f3, 1'b0, model_rf[rs1], sext12(imm)));
    endtask

    task automatic op_lui(input reg_addr_t rd, input logic [19:0] imm);
        issue({imm, rd, opc_lui}, rd, {imm, 12'h000});
    endtask

    task automatic op_auipc(input reg_addr_t rd, input logic [19:0] imm);
        issue({imm, rd, opc_auipc}, rd, pc_next + {imm, 12'h000});
    endtask

    task automatic op_sw(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
        model_mem[mem_index(model_rf[rs1] + sext12(imm))] = model_rf[rs2];
        issue({imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store}, 5'd0, 32'h0);
    endtask

    task automatic op_lw(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        issue({imm, rs1, 3'b010, rd, opc_load}, rd,
              model_mem[mem_index(model_rf[rs1] + sext12(imm))]);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_pc.size() != 0 && waited < hs_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_pc.size() != 0) begin
            err_proto++;
            $display("%0d instructions did not retire in time", exp_pc.size());
            exp_pc.delete();
            exp_rd.delete();
            exp_data.delete();
        end
    endtask

    task automatic retire_monitor();
        forever begin
            @(negedge clk);
            if (rst_n && retire_valid) begin
                if (exp_pc.size() == 0) begin
                    err_proto++;
                    $display("Retire at %0t with no instruction outstanding", $time);
                end else begin
                    check_word(retire_pc, exp_pc.pop_front(), "retire_pc");
                    check_reg_addr(retire_rd, exp_rd.pop_front(),
                                   $sformatf("retire_rd at pc %08h", retire_pc));
                    check_word(retire_data, exp_data.pop_front(),
                               $sformatf("retire_data at pc %08h", retire_pc));
                    n_retired++;
                end
            end
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        rst_n     = 1'b0;
        inst_req  = 1'b0;
        inst      = '0;
        pc        = '0;
        pc_next   = 32'h0000_1000;
        err_value = 0;
        err_proto = 0;
        n_sent    = 0;
        n_retired = 0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            model_mem[i] = '0;
        end
        void'($urandom(32'h787064d7));
        fork
            retire_monitor();
        join_none
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state_check();
        r_type_ops();
        i_type_and_upper();
        forwarding_chains();
        load_store_roundtrip();
        x0_writes();

        if (n_retired != n_sent) begin
            err_proto++;
            $display("Sent %0d instructions but %0d retired", n_sent, n_retired);
        end
        $display("Errors: %0d value, %0d protocol", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* operand_core.f */
+incdir+bench
source/rv_pkg.sv
source/fw_bus_if.sv
source/inst_decoder.sv
source/reg_file.sv
source/data_select_stage.sv
source/exec_stage.sv
source/mem_stage.sv
source/operand_core.sv
bench/tb_operand_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

log=sim_operand_core.log

if ! verilator --binary --timing -j 0 --top-module tb_operand_core \
        -f operand_core.f -o sim_operand_core; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_operand_core > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
    exit 1
fi
exit 0
